//--- hdl/rvPkg.sv
package rvPkg;

    typedef enum logic [6:0] {
        OPC_R      = 7'b0110011,
        OPC_IALU   = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcodeT;

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b1000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        SRA  = 4'b1101,
        OR   = 4'b0110,
        AND  = 4'b0111
    } aluOpT;

    typedef enum logic [2:0] {
        WB_ALU   = 3'd0,
        WB_MEM   = 3'd1,
        WB_IMM   = 3'd2,
        WB_PCIMM = 3'd3,
        WB_PC4   = 3'd4
    } wbSrcT;

    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMREAD   = 3'd3,
        MEMWRITE  = 3'd4,
        WRITEBACK = 3'd5,
        UPDATE    = 3'd6
    } cpuStateT;

    // funct3 codes
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL and SRA

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeT     opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcodeT      opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        opcodeT     opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10To5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4To1;
        logic       imm11;
        opcodeT     opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcodeT      opcode;
    } uTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10To1;
        logic       imm11;
        logic [7:0] imm19To12;
        logic [4:0] rd;
        opcodeT     opcode;
    } jTypeT;

    // One instruction word, several field layouts
    typedef union packed {
        rTypeT r;
        iTypeT i;
        sTypeT s;
        bTypeT b;
        uTypeT u;
        jTypeT j;
    } instrT;

endpackage

//--- hdl/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf import rvPkg::*; ();
    logic  regFileWe;
    aluOpT aluControl;
    logic  aluSrcMuxSel;     // 0 rs2, 1 immediate
    wbSrcT rfwdSrcMuxSel;
    logic  branch;
    logic  jal;              // Set for JAL and JALR
    logic  jalr;
    logic  pcEn;

    modport ctrl (
        output regFileWe, aluControl, aluSrcMuxSel, rfwdSrcMuxSel,
        output branch, jal, jalr, pcEn
    );

    modport dp (
        input regFileWe, aluControl, aluSrcMuxSel, rfwdSrcMuxSel,
        input branch, jal, jalr, pcEn
    );
endinterface

//--- hdl/RegisterFile.sv
`timescale 1ns/1ps

module RegisterFile (
    input  logic        clk,
    input  logic        we,
    input  logic [4:0]  rAddr1,
    input  logic [4:0]  rAddr2,
    input  logic [4:0]  wAddr,
    input  logic [31:0] wData,
    output logic [31:0] rData1,
    output logic [31:0] rData2
);
    logic [31:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[wAddr] <= wData;
        end
    end

    // x0 always reads zero
    assign rData1 = (rAddr1 != 5'd0) ? regs[rAddr1] : 32'b0;
    assign rData2 = (rAddr2 != 5'd0) ? regs[rAddr2] : 32'b0;

endmodule

//--- hdl/Alu.sv
`timescale 1ns/1ps

module Alu import rvPkg::*; (
    input  aluOpT       aluControl,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic        btaken,
    output logic [31:0] result
);
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (aluControl)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SRL:     result = a >> shamt;
            SRA:     result = $signed(a) >>> shamt;
            SLT:     result = {31'b0, $signed(a) < $signed(b)};
            SLTU:    result = {31'b0, a < b};
            XOR:     result = a ^ b;
            OR:      result = a | b;
            AND:     result = a & b;
            default: result = 32'b0;
        endcase
    end

    // Branch compare on funct3
    always_comb begin
        case (aluControl[2:0])
            F3_BEQ:  btaken = (a == b);
            F3_BNE:  btaken = (a != b);
            F3_BLT:  btaken = ($signed(a) < $signed(b));
            F3_BGE:  btaken = ($signed(a) >= $signed(b));
            F3_BLTU: btaken = (a < b);
            F3_BGEU: btaken = (a >= b);
            default: btaken = 1'b0;
        endcase
    end

endmodule

//--- hdl/ImmExtend.sv
`timescale 1ns/1ps

module ImmExtend import rvPkg::*; (
    input  logic [31:0] instrCode,
    output logic [31:0] immExt
);
    instrT instr;

    assign instr = instrCode;

    always_comb begin
        case (instr.i.opcode)
            OPC_LOAD, OPC_JALR: begin
                immExt = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            OPC_IALU: begin
                if (instr.i.funct3 == F3_SLL || instr.i.funct3 == F3_SR) begin
                    immExt = {27'b0, instr.i.imm[4:0]};    // Shift amount only
                end else begin
                    // SLTIU too, compared unsigned in the ALU
                    immExt = {{20{instr.i.imm[11]}}, instr.i.imm};
                end
            end
            OPC_STORE: begin
                immExt = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            end
            OPC_BRANCH: begin
                immExt = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                          instr.b.imm10To5, instr.b.imm4To1, 1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin
                immExt = {instr.u.imm, 12'b0};
            end
            OPC_JAL: begin
                immExt = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19To12,
                          instr.j.imm11, instr.j.imm10To1, 1'b0};
            end
            default: begin
                immExt = 32'b0;     // R-type has no immediate
            end
        endcase
    end

endmodule

//--- hdl/ControlUnit.sv
`timescale 1ns/1ps

module ControlUnit import rvPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instrCode,
    ctrlIf.ctrl         ctrlBus,
    output logic        dataWe
);
    instrT    instr;
    cpuStateT state;
    cpuStateT stateNext;
    logic     writesReg;    // Non-load instruction writing rd in EXECUTE

    assign instr = instrCode;

    // Instruction decode, held for the whole instruction
    always_comb begin
        ctrlBus.aluControl    = ADD;
        ctrlBus.aluSrcMuxSel  = 1'b0;
        ctrlBus.rfwdSrcMuxSel = WB_ALU;
        ctrlBus.branch        = 1'b0;
        ctrlBus.jal           = 1'b0;
        ctrlBus.jalr          = 1'b0;
        writesReg             = 1'b0;
        case (instr.r.opcode)
            OPC_R: begin
                ctrlBus.aluControl = aluOpT'({instr.r.funct7[5], instr.r.funct3});
                writesReg          = 1'b1;
            end
            OPC_IALU: begin
                ctrlBus.aluSrcMuxSel = 1'b1;
                if (instr.i.funct3 == F3_SR) begin
                    ctrlBus.aluControl = aluOpT'({instr.i.imm[10], instr.i.funct3});
                end else begin
                    ctrlBus.aluControl = aluOpT'({1'b0, instr.i.funct3});
                end
                writesReg = 1'b1;
            end
            OPC_LOAD: begin
                ctrlBus.aluSrcMuxSel  = 1'b1;
                ctrlBus.rfwdSrcMuxSel = WB_MEM;
            end
            OPC_STORE: begin
                ctrlBus.aluSrcMuxSel = 1'b1;
            end
            OPC_BRANCH: begin
                // Low bits select the comparison
                ctrlBus.aluControl = aluOpT'({1'b0, instr.b.funct3});
                ctrlBus.branch     = 1'b1;
            end
            OPC_LUI: begin
                ctrlBus.rfwdSrcMuxSel = WB_IMM;
                writesReg             = 1'b1;
            end
            OPC_AUIPC: begin
                ctrlBus.rfwdSrcMuxSel = WB_PCIMM;
                writesReg             = 1'b1;
            end
            OPC_JAL: begin
                ctrlBus.rfwdSrcMuxSel = WB_PC4;
                ctrlBus.jal           = 1'b1;
                writesReg             = 1'b1;
            end
            OPC_JALR: begin
                ctrlBus.rfwdSrcMuxSel = WB_PC4;
                ctrlBus.jal           = 1'b1;
                ctrlBus.jalr          = 1'b1;  // rs1 as target base
                writesReg             = 1'b1;
            end
            default: begin
                writesReg = 1'b0;   // Unknown opcode runs as a NOP
            end
        endcase
    end

    always_comb begin
        stateNext = state;
        case (state)
            FETCH:   stateNext = DECODE;
            DECODE:  stateNext = EXECUTE;
            EXECUTE: begin
                if (instr.r.opcode == OPC_LOAD) begin
                    stateNext = MEMREAD;
                end else if (instr.r.opcode == OPC_STORE) begin
                    stateNext = MEMWRITE;
                end else begin
                    stateNext = UPDATE;
                end
            end
            MEMREAD: stateNext = WRITEBACK;
            default: stateNext = FETCH;   // MEMWRITE, WRITEBACK, UPDATE
        endcase
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= stateNext;
        end
    end

    assign ctrlBus.regFileWe = ((state == EXECUTE) && writesReg) || (state == WRITEBACK);
    assign ctrlBus.pcEn      = state inside {UPDATE, MEMWRITE, WRITEBACK};
    assign dataWe            = (state == MEMWRITE);

    // Fetch, decode and execute of the next instruction follow with the PC held
    pcEnLastState: assert property (@(posedge clk) disable iff (reset)
        ctrlBus.pcEn |=> !ctrlBus.pcEn ##1 !ctrlBus.pcEn ##1 !ctrlBus.pcEn)
        else $error("pcEn outside the last state of an instruction");

    weExclusive: assert property (@(posedge clk) disable iff (reset)
        !(dataWe && ctrlBus.regFileWe))
        else $error("dataWe and regFileWe high together");

endmodule

//--- hdl/DataPath.sv
`timescale 1ns/1ps

module DataPath import rvPkg::*; (
    input  logic        clk,
    input  logic        reset,
    ctrlIf.dp           ctrlBus,
    output logic [31:0] instrMemAddr,
    input  logic [31:0] instrCode,
    output logic [31:0] dataAddr,
    output logic [31:0] dataWData,
    input  logic [31:0] dataRData
);
    logic [31:0] pc;
    logic [31:0] rfData1;
    logic [31:0] rfData2;
    logic [31:0] rfWData;
    logic [31:0] immExt;
    logic [31:0] decRfData1;
    logic [31:0] decRfData2;
    logic [31:0] decImmExt;
    logic [31:0] aluSrcB;
    logic [31:0] aluResult;
    logic        btaken;
    logic        pcSrcSel;
    logic [31:0] pcImmBase;
    logic [31:0] pcImmSum;
    logic [31:0] pcImmResult;
    logic [31:0] pcPlus4;
    logic [31:0] pcNext;
    logic [31:0] exeAluResult;
    logic [31:0] exeRfData2;
    logic [31:0] exePcNext;
    logic [31:0] memRData;

    assign instrMemAddr = pc;
    assign dataAddr     = exeAluResult;
    assign dataWData    = exeRfData2;

    RegisterFile uRegFile (
        .clk    (clk),
        .we     (ctrlBus.regFileWe),
        .rAddr1 (instrCode[19:15]),
        .rAddr2 (instrCode[24:20]),
        .wAddr  (instrCode[11:7]),
        .wData  (rfWData),
        .rData1 (rfData1),
        .rData2 (rfData2)
    );

    ImmExtend uImmExtend (
        .instrCode (instrCode),
        .immExt    (immExt)
    );

    assign aluSrcB = ctrlBus.aluSrcMuxSel ? decImmExt : decRfData2;

    Alu uAlu (
        .aluControl (ctrlBus.aluControl),
        .a          (decRfData1),
        .b          (aluSrcB),
        .btaken     (btaken),
        .result     (aluResult)
    );

    // Next PC and jump target
    always_comb begin
        pcImmBase   = ctrlBus.jalr ? decRfData1 : pc;
        pcImmSum    = pcImmBase + decImmExt;
        pcImmResult = {pcImmSum[31:1], pcImmSum[0] & ~ctrlBus.jalr};  // JALR clears bit 0
        pcPlus4     = pc + 32'd4;
        pcSrcSel    = ctrlBus.jal | (ctrlBus.branch & btaken);
        pcNext      = pcSrcSel ? pcImmResult : pcPlus4;
    end

    always_comb begin
        case (ctrlBus.rfwdSrcMuxSel)
            WB_ALU:   rfWData = aluResult;
            WB_MEM:   rfWData = memRData;
            WB_IMM:   rfWData = decImmExt;
            WB_PCIMM: rfWData = pcImmResult;
            WB_PC4:   rfWData = pcPlus4;
            default:  rfWData = 32'b0;
        endcase
    end

    // Decode, execute and memory stage registers
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            decRfData1   <= 32'b0;
            decRfData2   <= 32'b0;
            decImmExt    <= 32'b0;
            exeAluResult <= 32'b0;
            exeRfData2   <= 32'b0;
            exePcNext    <= 32'b0;
            memRData     <= 32'b0;
        end else begin
            decRfData1   <= rfData1;
            decRfData2   <= rfData2;
            decImmExt    <= immExt;
            exeAluResult <= aluResult;
            exeRfData2   <= decRfData2;
            exePcNext    <= pcNext;
            memRData     <= dataRData;
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            pc <= 32'b0;
        end else if (ctrlBus.pcEn) begin
            pc <= exePcNext;
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (reset)
        ctrlBus.pcEn |=> (pc[1:0] == 2'b00))
        else $error("PC not word aligned: %h", pc);

endmodule

//--- hdl/CpuTop.sv
`timescale 1ns/1ps

module CpuTop (
    input  logic        clk,
    input  logic        reset,
    // Instruction memory
    output logic [31:0] instrMemAddr,
    input  logic [31:0] instrCode,
    // Data memory
    output logic [31:0] dataAddr,
    output logic [31:0] dataWData,
    input  logic [31:0] dataRData,
    output logic        dataWe
);
    ctrlIf ctrlBus ();

    ControlUnit uCtrl (
        .clk       (clk),
        .reset     (reset),
        .instrCode (instrCode),
        .ctrlBus   (ctrlBus.ctrl),
        .dataWe    (dataWe)
    );

    DataPath uDataPath (
        .clk          (clk),
        .reset        (reset),
        .ctrlBus      (ctrlBus.dp),
        .instrMemAddr (instrMemAddr),
        .instrCode    (instrCode),
        .dataAddr     (dataAddr),
        .dataWData    (dataWData),
        .dataRData    (dataRData)
    );

endmodule

//--- dv/tbCpu.sv
`timescale 1ns/1ps

module tbCpu import rvPkg::*; ();
    localparam int TIMEOUT      = 200;
    localparam int QUIET_CYCLES = 40;

    logic        clk;
    logic        reset;
    logic [31:0] instrMemAddr;
    logic [31:0] instrCode;
    logic [31:0] dataAddr;
    logic [31:0] dataWData;
    logic [31:0] dataRData;
    logic        dataWe;

    logic [31:0] prog [0:255];
    int          progLen;
    logic [31:0] dmem [0:63];

    // Expected stores in program order
    logic [31:0] expAddr [0:63];
    logic [31:0] expData [0:63];
    logic [31:0] expPc [0:63];     // Address of the store instruction
    int          numExp;
    logic [31:0] storeAddr;    // Next free data address

    logic [31:0] seed;
    logic [31:0] opA;          // Positive operand in x1
    logic [31:0] opB;
    logic [31:0] opC;          // Negative operand in x3
    int          errors;
    int          checks;
    logic        timedOut;

    CpuTop i_dut (
        .clk          (clk),
        .reset        (reset),
        .instrMemAddr (instrMemAddr),
        .instrCode    (instrCode),
        .dataAddr     (dataAddr),
        .dataWData    (dataWData),
        .dataRData    (dataRData),
        .dataWe       (dataWe)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Both memories answer in the same cycle
    assign instrCode = (instrMemAddr < 32'(progLen * 4)) ? prog[instrMemAddr[9:2]] : 32'h13;
    assign dataRData = dmem[dataAddr[7:2]];

    always @(posedge clk) begin
        if (dataWe) begin
            dmem[dataAddr[7:2]] <= dataWData;
        end
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_R};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};   // SW
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
            input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] v1,
            input logic [31:0] v2);
        case (f3)
            3'b000:  return v1 == v2;
            3'b001:  return v1 != v2;
            3'b100:  return $signed(v1) < $signed(v2);
            3'b101:  return $signed(v1) >= $signed(v2);
            3'b110:  return v1 < v2;
            3'b111:  return v1 >= v2;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] nextPc();
        return 32'(progLen * 4);
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    // LUI then ADDI, upper part rounded for the sign of the low twelve bits
    task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        emit(encU(upper[31:12], rd, OPC_LUI));
        emit(encI(value[11:0], rd, 3'b000, rd, OPC_IALU));
    endtask

    task automatic storeReg(input logic [4:0] rs, input logic [31:0] value,
            input logic expected);
        if (expected) begin
            expAddr[numExp] = storeAddr;
            expData[numExp] = value;
            expPc[numExp]   = nextPc();
            numExp++;
        end
        emit(encS(storeAddr[11:0], rs, 5'd0));
        storeAddr = storeAddr + 32'd4;
    endtask

    task automatic opReg(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [31:0] value);
        emit(encR(f7, rs2, rs1, f3, 5'd4));
        storeReg(5'd4, value, 1'b1);
    endtask

    task automatic opImm(input logic [11:0] imm, input logic [2:0] f3, input logic [4:0] rs1,
            input logic [31:0] value);
        emit(encI(imm, rs1, f3, 5'd4, OPC_IALU));
        storeReg(5'd4, value, 1'b1);
    endtask

    // A taken branch jumps over the store behind it
    task automatic branchCase(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
            input logic [31:0] v1, input logic [31:0] v2);
        emit(encB(13'd8, rs2, rs1, f3));
        storeReg(5'd1, opA, !branchTaken(f3, v1, v2));
    endtask

    task automatic buildProgram();
        logic [31:0] imm;
        logic [31:0] sx;
        logic [4:0]  sh;
        logic [31:0] pc;
        logic [2:0]  brF3 [0:5];
        int          k;
        brF3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        seed = 32'h568d;
        seed = lcg(seed);
        opA  = {1'b0, seed[30:0]};
        seed = lcg(seed);
        opB  = {seed[31:5], 1'b1, seed[3:0]};   // Shift amount 16 to 31
        seed = lcg(seed);
        opC  = {1'b1, seed[30:0]};
        seed = lcg(seed);
        imm  = seed;
        sx   = {{20{imm[11]}}, imm[11:0]};
        sh   = {2'b01, imm[14:12]};
        loadConst(5'd1, opA);
        loadConst(5'd2, opB);
        loadConst(5'd3, opC);
        opReg(7'h00, 3'b000, 5'd1, 5'd2, opA + opB);
        opReg(7'h20, 3'b000, 5'd1, 5'd2, opA - opB);
        opReg(7'h00, 3'b001, 5'd1, 5'd2, opA << opB[4:0]);
        opReg(7'h00, 3'b101, 5'd1, 5'd2, opA >> opB[4:0]);
        opReg(7'h20, 3'b101, 5'd3, 5'd2, $signed(opC) >>> opB[4:0]);
        opReg(7'h00, 3'b010, 5'd1, 5'd2, ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0);
        opReg(7'h00, 3'b010, 5'd3, 5'd1, 32'd1);
        opReg(7'h00, 3'b011, 5'd1, 5'd2, (opA < opB) ? 32'd1 : 32'd0);
        opReg(7'h00, 3'b100, 5'd1, 5'd2, opA ^ opB);
        opReg(7'h00, 3'b110, 5'd1, 5'd2, opA | opB);
        opReg(7'h00, 3'b111, 5'd1, 5'd2, opA & opB);
        emit(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));   // ADD x0, x1, x2
        storeReg(5'd0, 32'd0, 1'b1);
        opImm(imm[11:0], 3'b000, 5'd1, opA + sx);
        opImm(imm[11:0], 3'b010, 5'd1, ($signed(opA) < $signed(sx)) ? 32'd1 : 32'd0);
        opImm(imm[11:0], 3'b011, 5'd1, (opA < sx) ? 32'd1 : 32'd0);
        opImm(imm[11:0], 3'b100, 5'd1, opA ^ sx);
        opImm(imm[11:0], 3'b110, 5'd1, opA | sx);
        opImm(imm[11:0], 3'b111, 5'd1, opA & sx);
        opImm({7'h00, sh}, 3'b001, 5'd1, opA << sh);
        opImm({7'h00, sh}, 3'b101, 5'd3, opC >> sh);
        opImm({7'h20, sh}, 3'b101, 5'd3, $signed(opC) >>> sh);
        emit(encU(imm[31:12], 5'd5, OPC_LUI));
        storeReg(5'd5, {imm[31:12], 12'b0}, 1'b1);
        pc = nextPc();
        emit(encU(imm[31:12], 5'd5, OPC_AUIPC));
        storeReg(5'd5, pc + {imm[31:12], 12'b0}, 1'b1);
        storeReg(5'd3, opC, 1'b1);
        emit(encI(storeAddr[11:0] - 12'd4, 5'd0, 3'b010, 5'd6, OPC_LOAD));   // LW back
        storeReg(5'd6, opC, 1'b1);
        for (k = 0; k < 6; k++) begin
            if (brF3[k][2] == 1'b0) begin
                branchCase(brF3[k], 5'd1, 5'd1, opA, opA);
            end else begin
                branchCase(brF3[k], 5'd3, 5'd1, opC, opA);
            end
            branchCase(brF3[k], 5'd1, 5'd3, opA, opC);
        end
        pc = nextPc();
        emit(encJ(21'd8, 5'd8));
        storeReg(5'd1, opA, 1'b0);
        storeReg(5'd8, pc + 32'd4, 1'b1);
        pc = nextPc() + 32'd4;    // Address of the JALR
        emit(encI(pc[11:0] + 12'd6, 5'd0, 3'b000, 5'd9, OPC_IALU));
        emit(encI(12'd3, 5'd9, 3'b000, 5'd10, OPC_JALR));   // Odd sum, bit 0 dropped
        storeReg(5'd1, opA, 1'b0);
        storeReg(5'd10, pc + 32'd4, 1'b1);
        emit(encJ(21'd0, 5'd0));   // Park
    endtask

    task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic waitStore(output logic seen);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!dataWe && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        seen = dataWe;
    endtask

    initial begin
        logic seen;
        int   k;
        reset     = 1'b1;
        errors    = 0;
        checks    = 0;
        timedOut  = 1'b0;
        progLen   = 0;
        numExp    = 0;
        storeAddr = 32'd0;
        for (k = 0; k < 64; k++) begin
            dmem[k] = 32'hd5a0_0000 ^ (32'(k) * 32'h0001_0101);
        end
        buildProgram();
        repeat (16) @(negedge clk);
        reset = 1'b0;
        checkEq("fetch address after reset", instrMemAddr, 32'd0);
        checkEq("dataWe after reset", {31'b0, dataWe}, 32'd0);
        for (k = 0; k < numExp && !timedOut; k++) begin
            waitStore(seen);
            if (!seen) begin
                errors++;
                timedOut = 1'b1;
                $display("Timed out waiting for store %0d of %0d", k, numExp);
            end else begin
                checkEq($sformatf("store %0d fetch address", k), instrMemAddr, expPc[k]);
                checkEq($sformatf("store %0d address", k), dataAddr, expAddr[k]);
                checkEq($sformatf("store %0d data", k), dataWData, expData[k]);
            end
        end
        if (!timedOut) begin
            for (k = 0; k < QUIET_CYCLES; k++) begin
                @(negedge clk);
                if (dataWe) begin
                    errors++;
                    $display("ERROR %0t: unexpected store to %h", $time, dataAddr);
                end
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
hdl/rvPkg.sv
hdl/ctrlIf.sv
hdl/RegisterFile.sv
hdl/Alu.sv
hdl/ImmExtend.sv
hdl/ControlUnit.sv
hdl/DataPath.sv
hdl/CpuTop.sv
dv/tbCpu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbCpu -f flist.f -o simCpu
./obj_dir/simCpu | tee sim.log

if grep -q "^Simulation finished: PASS$" sim.log; then
    echo "Run passed"
    exit 0
fi
echo "Run failed"
exit 1
